/* design/cache_pkg.sv */
// cache_pkg: address union, cache field widths, load/store size codes
package cache_pkg;

    // geometry: 512 sets of one word, two ways
    localparam int TAG_BITS    = 21;
    localparam int SET_BITS    = 9;
    localparam int OFFSET_BITS = 2;
    localparam int SETS        = 1 << SET_BITS;

    // low two bits of funct3 give the access size
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // funct3 bit 2 set means zero extension on loads
    localparam int UNSIGNED_BIT = 2;

    // one address word, seen either whole or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_BITS-1:0]    tag;
            logic [SET_BITS-1:0]    set;
            logic [OFFSET_BITS-1:0] offset;
        } fields;
    } addr_u;

endpackage

/* design/cache_ctrl.sv */
// cache_ctrl: five-state controller for lookup, write-back, refill and response
`timescale 1ns/1ps

module cache_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    input  logic req_write,     // latched write flag of the current request
    input  logic rsp_ready,
    input  logic hit,
    input  logic victim_dirty,
    input  logic mem_done,
    output logic req_ready,
    output logic rsp_valid,
    output logic req_take,
    output logic way_write,
    output logic refill,
    output logic wb_sel,
    output logic mem_start,
    output logic mem_write
);

    localparam logic [2:0] IDLE      = 3'd0;
    localparam logic [2:0] LOOKUP    = 3'd1;
    localparam logic [2:0] WRITEBACK = 3'd2;
    localparam logic [2:0] REFILL    = 3'd3;
    localparam logic [2:0] RESPOND   = 3'd4;

    logic [2:0] state;
    logic [2:0] state_nxt;
    logic       refill_pending;     // first REFILL cycle after a write-back

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (req_valid) state_nxt = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    state_nxt = RESPOND;
                end else if (victim_dirty) begin
                    state_nxt = WRITEBACK;
                end else begin
                    state_nxt = REFILL;
                end
            end
            WRITEBACK: if (mem_done) state_nxt = REFILL;
            REFILL:    if (mem_done) state_nxt = LOOKUP;    // retry, now hits
            RESPOND:   if (rsp_ready) state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= IDLE;
            refill_pending <= 1'b0;
        end else begin
            state          <= state_nxt;
            refill_pending <= (state == WRITEBACK) && mem_done;
        end
    end

    assign req_ready = (state == IDLE);
    assign rsp_valid = (state == RESPOND);
    assign req_take  = req_ready && req_valid;

    // stores only ever write through the hit path
    assign way_write = (state == LOOKUP) && hit && req_write;
    assign refill    = (state == REFILL) && mem_done;

    // victim address and write direction for the whole write-back
    assign wb_sel    = (state == WRITEBACK);
    assign mem_write = (state == WRITEBACK);

    // transfer starts on a miss, or right after the victim has gone out
    assign mem_start = ((state == LOOKUP) && !hit) || ((state == REFILL) && refill_pending);

endmodule

/* design/mem_wait_timer.sv */
// mem_wait_timer: down-counter timing each backing-memory transfer
`timescale 1ns/1ps

module mem_wait_timer #(
    parameter int MEM_LATENCY = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic mem_start,
    output logic mem_done,
    output logic mem_busy
);

    localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_busy <= 1'b0;
            count    <= '0;
        end else if (mem_start) begin
            mem_busy <= 1'b1;
            count    <= CNT_BITS'(MEM_LATENCY - 1);     // done lands MEM_LATENCY cycles later
        end else if (mem_busy) begin
            if (count == '0) begin
                mem_busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign mem_done = mem_busy && (count == '0);   // single-cycle pulse

endmodule

/* design/cache_ways.sv */
// cache_ways: request latch, two-way tag/data/valid/dirty arrays, recently-used bits
`timescale 1ns/1ps

module cache_ways (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_take,
    input  logic [31:0]       req_addr,
    input  logic              req_write,
    input  logic [2:0]        req_funct3,
    input  logic [31:0]       req_wdata,
    input  logic              way_write,
    input  logic              refill,
    input  logic              wb_sel,
    input  logic [31:0]       merged_word,
    input  logic [31:0]       mem_rdata,
    output logic              hit,
    output logic              hit_way,
    output logic              victim_dirty,
    output logic [31:0]       word_out,
    output logic [31:0]       victim_word,
    output cache_pkg::addr_u  mem_addr,
    output logic [1:0]        cur_offset,
    output logic [2:0]        cur_funct3,
    output logic [31:0]       cur_wdata,
    output logic              cur_write
);

    cache_pkg::addr_u cur_addr;

    logic [cache_pkg::TAG_BITS-1:0] tag_mem  [2][cache_pkg::SETS];
    logic [31:0]                    data_mem [2][cache_pkg::SETS];
    logic [1:0][cache_pkg::SETS-1:0] valid;
    logic [1:0][cache_pkg::SETS-1:0] dirty;
    logic [cache_pkg::SETS-1:0]      mru;      // 1 = way 1 used last

    logic [cache_pkg::SET_BITS-1:0] set_idx;
    logic [1:0]                     way_hit;
    logic                           victim;

    // request payload, held for the whole access
    always_ff @(posedge clk) begin
        if (req_take) begin
            cur_addr.raw <= req_addr;
            cur_funct3   <= req_funct3;
            cur_wdata    <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_write <= 1'b0;
        end else if (req_take) begin
            cur_write <= req_write;
        end
    end

    assign set_idx    = cur_addr.fields.set;
    assign cur_offset = cur_addr.fields.offset;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid[w][set_idx] && (tag_mem[w][set_idx] == cur_addr.fields.tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];
    assign victim  = ~mru[set_idx];     // evict the way not used last

    assign word_out     = data_mem[hit_way][set_idx];
    assign victim_word  = data_mem[victim][set_idx];
    assign victim_dirty = valid[victim][set_idx] && dirty[victim][set_idx];

    // word address of the victim during write-back, else of the request
    always_comb begin
        mem_addr.fields.tag    = wb_sel ? tag_mem[victim][set_idx] : cur_addr.fields.tag;
        mem_addr.fields.set    = set_idx;
        mem_addr.fields.offset = '0;
    end

    always_ff @(posedge clk) begin
        if (way_write) begin
            data_mem[hit_way][set_idx] <= merged_word;
        end
        if (refill) begin
            data_mem[victim][set_idx] <= mem_rdata;
            tag_mem[victim][set_idx]  <= cur_addr.fields.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
            mru   <= '0;
        end else if (refill) begin
            valid[victim][set_idx] <= 1'b1;
            dirty[victim][set_idx] <= 1'b0;
            mru[set_idx]           <= victim;
        end else if (hit) begin
            // same way every cycle of one access, so repeats are harmless
            mru[set_idx] <= hit_way;
            if (way_write) begin
                dirty[hit_way][set_idx] <= 1'b1;
            end
        end
    end

endmodule

/* design/load_store_align.sv */
// load_store_align: store lane merge and load lane extraction with extension
`timescale 1ns/1ps

module load_store_align (
    input  logic [31:0] word_out,
    input  logic [31:0] cur_wdata,
    input  logic [2:0]  cur_funct3,
    input  logic [1:0]  cur_offset,
    output logic [31:0] merged_word,
    output logic [31:0] rsp_rdata
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        zext;

    assign byte_sel = word_out[{cur_offset, 3'b000} +: 8];
    assign half_sel = word_out[{cur_offset[1], 4'b0000} +: 16];    // offset bit 0 ignored
    assign zext     = cur_funct3[cache_pkg::UNSIGNED_BIT];

    // store path, only the addressed lane changes
    always_comb begin
        merged_word = word_out;
        case (cur_funct3[1:0])
            cache_pkg::SIZE_BYTE: merged_word[{cur_offset, 3'b000} +: 8] = cur_wdata[7:0];
            cache_pkg::SIZE_HALF: merged_word[{cur_offset[1], 4'b0000} +: 16] = cur_wdata[15:0];
            cache_pkg::SIZE_WORD: merged_word = cur_wdata;
            default: ;
        endcase
    end

    // load path
    always_comb begin
        rsp_rdata = '0;     // unknown codes read as zero
        case (cur_funct3[1:0])
            cache_pkg::SIZE_BYTE: begin
                rsp_rdata = zext ? {24'b0, byte_sel} : {{24{byte_sel[7]}}, byte_sel};
            end
            cache_pkg::SIZE_HALF: begin
                rsp_rdata = zext ? {16'b0, half_sel} : {{16{half_sel[15]}}, half_sel};
            end
            cache_pkg::SIZE_WORD: begin
                if (!zext) begin
                    rsp_rdata = word_out;   // no LWU on RV32
                end
            end
            default: ;
        endcase
    end

endmodule

/* design/backing_mem.sv */
// backing_mem: word-addressed main memory model behind the cache
`timescale 1ns/1ps

module backing_mem #(
    parameter int MEM_WORDS = 4096
) (
    input  logic             clk,
    input  logic             mem_done,
    input  logic             mem_write,
    input  cache_pkg::addr_u mem_addr,
    input  logic [31:0]      victim_word,
    output logic [31:0]      mem_rdata
);

    localparam int IDX_BITS = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];
    logic [cache_pkg::TAG_BITS+cache_pkg::SET_BITS-1:0] word_addr;
    logic [IDX_BITS-1:0] idx;

    assign word_addr = {mem_addr.fields.tag, mem_addr.fields.set};
    assign idx       = word_addr[IDX_BITS-1:0];    // wraps modulo depth

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // address is steady through a transfer, so the registered read word
    // is already current by the time mem_done pulses
    always_ff @(posedge clk) begin
        if (mem_done && mem_write) begin
            mem[idx] <= victim_word;
        end else begin
            mem_rdata <= mem[idx];
        end
    end

endmodule

/* design/data_cache_top.sv */
// data_cache_top: controller, timer, ways, aligner and backing memory
`timescale 1ns/1ps

module data_cache_top #(
    parameter int MEM_LATENCY = 4,
    parameter int MEM_WORDS   = 4096
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic        req_write,
    input  logic [2:0]  req_funct3,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_wdata,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output logic [31:0] rsp_rdata
);

    logic             req_take;
    logic             way_write;
    logic             refill;
    logic             wb_sel;
    logic             mem_start;
    logic             mem_write;
    logic             mem_done;
    logic             mem_busy;
    logic             hit;
    logic             victim_dirty;
    logic [31:0]      word_out;
    logic [31:0]      victim_word;
    logic [31:0]      mem_rdata;
    logic [31:0]      merged_word;
    cache_pkg::addr_u mem_addr;
    logic [1:0]       cur_offset;
    logic [2:0]       cur_funct3;
    logic [31:0]      cur_wdata;
    logic             cur_write;

    cache_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(cur_write), .rsp_ready(rsp_ready),
        .hit(hit), .victim_dirty(victim_dirty), .mem_done(mem_done),
        .req_ready(req_ready), .rsp_valid(rsp_valid), .req_take(req_take),
        .way_write(way_write), .refill(refill), .wb_sel(wb_sel),
        .mem_start(mem_start), .mem_write(mem_write)
    );

    mem_wait_timer #(.MEM_LATENCY(MEM_LATENCY)) u_timer (
        .clk(clk), .rst(rst), .mem_start(mem_start),
        .mem_done(mem_done), .mem_busy(mem_busy)
    );

    cache_ways u_ways (
        .clk(clk), .rst(rst), .req_take(req_take), .req_addr(req_addr),
        .req_write(req_write), .req_funct3(req_funct3), .req_wdata(req_wdata),
        .way_write(way_write), .refill(refill), .wb_sel(wb_sel),
        .merged_word(merged_word), .mem_rdata(mem_rdata),
        .hit(hit), .hit_way(), .victim_dirty(victim_dirty),
        .word_out(word_out), .victim_word(victim_word), .mem_addr(mem_addr),
        .cur_offset(cur_offset), .cur_funct3(cur_funct3),
        .cur_wdata(cur_wdata), .cur_write(cur_write)
    );

    load_store_align u_align (
        .word_out(word_out), .cur_wdata(cur_wdata), .cur_funct3(cur_funct3),
        .cur_offset(cur_offset), .merged_word(merged_word), .rsp_rdata(rsp_rdata)
    );

    backing_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk(clk), .mem_done(mem_done), .mem_write(mem_write),
        .mem_addr(mem_addr), .victim_word(victim_word), .mem_rdata(mem_rdata)
    );

endmodule

/* bench/cache_assertions.sv */
// cache_assertions: handshake and memory timing checks, bound into data_cache_top
`timescale 1ns/1ps

module cache_assertions #(
    parameter int MEM_LATENCY = 4
) (
    input logic        clk,
    input logic        rst,
    input logic        req_ready,
    input logic        rsp_valid,
    input logic        rsp_ready,
    input logic [31:0] rsp_rdata,
    input logic        mem_start,
    input logic        mem_done,
    input logic        mem_busy
);

    int failures = 0;   // failed assertion count

    // controller is either taking a request or offering a response
    ready_valid_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(req_ready && rsp_valid))
        else begin
            $error("req_ready and rsp_valid high in the same cycle");
            failures++;
        end

    // held response must not change under back-pressure
    response_held: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata)))
        else begin
            $error("response dropped or changed before rsp_ready");
            failures++;
        end

    done_after_start: assert property (@(posedge clk) disable iff (rst)
        $past(mem_start, MEM_LATENCY) |-> mem_done)
        else begin
            $error("mem_done missing MEM_LATENCY cycles after mem_start");
            failures++;
        end

    // and never at any other distance
    done_only_when_due: assert property (@(posedge clk) disable iff (rst)
        mem_done |-> $past(mem_start, MEM_LATENCY))
        else begin
            $error("mem_done without a matching mem_start");
            failures++;
        end

    // one transfer at a time
    no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
        mem_start |-> !mem_busy)
        else begin
            $error("mem_start while a transfer is still in flight");
            failures++;
        end

endmodule

bind data_cache_top cache_assertions #(.MEM_LATENCY(MEM_LATENCY)) u_assertions (
    .clk(clk), .rst(rst), .req_ready(req_ready), .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
    .mem_start(mem_start), .mem_done(mem_done), .mem_busy(mem_busy)
);

/* bench/cache_tb.sv */
// cache_tb: clock, reset, LFSR, shadow memory, directed cache tests and summary
`timescale 1ns/1ps

module cache_tb;

    localparam int MEM_LATENCY    = 4;
    localparam int HIT_CYCLES     = 2;
    localparam int MISS_CLEAN     = HIT_CYCLES + MEM_LATENCY + 1;
    localparam int MISS_DIRTY     = MISS_CLEAN + MEM_LATENCY + 1;
    localparam int TIMEOUT_CYCLES = 100;

    // funct3 access codes
    localparam logic [2:0] LB  = 3'd0;
    localparam logic [2:0] LH  = 3'd1;
    localparam logic [2:0] LW  = 3'd2;
    localparam logic [2:0] LBU = 3'd4;
    localparam logic [2:0] LHU = 3'd5;
    localparam logic [2:0] SB  = 3'd0;
    localparam logic [2:0] SH  = 3'd1;
    localparam logic [2:0] SW  = 3'd2;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    logic        req_write;
    logic [2:0]  req_funct3;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_rdata;

    logic [31:0] shadow [4096];     // word image of what memory should hold
    logic [31:0] lfsr = 32'h63bc;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    data_cache_top uut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
        .req_funct3(req_funct3), .req_addr(req_addr), .req_wdata(req_wdata),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic logic [31:0] make_addr(input logic [20:0] tag, input logic [8:0] set,
                                              input logic [1:0] off);
        return {tag, set, off};
    endfunction

    // expected word after a store of the given size
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [2:0] f3, input logic [1:0] off);
        logic [31:0] mask;
        logic [4:0]  sh;
        if (f3[1:0] == 2'd2) begin
            return wdata;
        end
        sh   = (f3[1:0] == 2'd0) ? {off, 3'b000} : {off[1], 4'b0000};
        mask = ((f3[1:0] == 2'd0) ? 32'h0000_00ff : 32'h0000_ffff) << sh;
        if (f3[1:0] == 2'd3) begin
            return old;
        end
        return (old & ~mask) | ((wdata << sh) & mask);
    endfunction

    function automatic logic [31:0] extract_load(input logic [31:0] word, input logic [2:0] f3,
                                                 input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (off * 8));
        h = 16'(word >> (off[1] * 16));
        case (f3)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'b0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'b0, h};
            LW:      return word;
            default: return 32'b0;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_and_finish();
        int assert_fails;
        assert_fails = uut.u_assertions.failures;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("ERROR at %0t ns: %s", $time, why);
        report_and_finish();
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // one request/response; loads are checked, stores update the shadow
    task automatic do_access(input logic write, input logic [2:0] f3, input logic [31:0] addr,
                             input logic [31:0] wdata, input int hold, output int lat);
        int          waited;
        logic [31:0] got;
        logic [11:0] idx;
        idx = addr[13:2];
        @(posedge clk);
        req_valid  <= 1'b1;
        req_write  <= write;
        req_funct3 <= f3;
        req_addr   <= addr;
        req_wdata  <= wdata;
        rsp_ready  <= (hold == 0);
        waited = 0;
        @(negedge clk);
        while (!req_ready) begin
            if (waited == TIMEOUT_CYCLES) abort_run("request was never accepted");
            @(negedge clk);
            waited++;
        end
        @(posedge clk);     // accepting edge
        req_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT_CYCLES) abort_run("no response arrived within the timeout");
        end while (!rsp_valid);
        got = rsp_rdata;
        if (hold > 0) begin
            repeat (hold) @(posedge clk);
            rsp_ready <= 1'b1;
        end
        @(posedge clk);     // response transfer
        if (write) begin
            shadow[idx] = merge_store(shadow[idx], wdata, f3, addr[1:0]);
        end else begin
            check_value(got, extract_load(shadow[idx], f3, addr[1:0]),
                        $sformatf("load f3=%0d addr %h", f3, addr));
        end
    endtask

    task automatic reset_state();
        int e0;
        int lat;
        e0 = errors;
        @(negedge clk);
        check_value(32'(req_ready), 32'd1, "req_ready after reset");
        check_value(32'(rsp_valid), 32'd0, "rsp_valid after reset");
        do_access(1'b0, LW, 32'h0000_2000, 32'h0, 0, lat);
        end_test("reset_state", e0);
    endtask

    task automatic word_round_trip();
        int e0;
        int lat;
        e0 = errors;
        do_access(1'b1, SW, 32'h0000_0404, 32'hdead_beef, 0, lat);
        do_access(1'b0, LW, 32'h0000_0404, 32'h0, 0, lat);
        check_value(32'(lat), 32'(HIT_CYCLES), "hit latency after store allocate");
        end_test("word_round_trip", e0);
    endtask

    task automatic load_every_lane(input logic [31:0] base);
        logic [2:0] codes [5];
        int         lat;
        codes = '{LB, LH, LW, LBU, LHU};
        for (int off = 0; off < 4; off++) begin
            for (int k = 0; k < 5; k++) begin
                do_access(1'b0, codes[k], base + 32'(off), 32'h0, 0, lat);
            end
        end
    endtask

    task automatic subword_access();
        int          e0;
        int          lat;
        logic [31:0] base;
        e0   = errors;
        base = 32'h0000_0810;
        do_access(1'b1, SW, base, 32'h1122_3344, 0, lat);
        for (int i = 0; i < 4; i++) begin
            do_access(1'b1, SB, base + 32'(i), 32'hcafe_0070 + 32'(i * 24), 0, lat);
        end
        load_every_lane(base);
        // offset bit 0 is ignored, so each half is written twice
        for (int i = 0; i < 4; i++) begin
            do_access(1'b1, SH, base + 32'(i), 32'h1234_fe00 + 32'(i * 4371), 0, lat);
            do_access(1'b0, LW, base, 32'h0, 0, lat);
        end
        load_every_lane(base);
        end_test("subword", e0);
    endtask

    task automatic dirty_eviction();
        int e0;
        int lat;
        e0 = errors;
        for (int t = 1; t <= 3; t++) begin
            do_access(1'b1, SW, make_addr(21'(t), 9'd200, 2'd0), 32'h5a00_0000 + 32'(t * 257),
                      0, lat);
        end
        check_value(32'(lat), 32'(MISS_DIRTY), "store latency with dirty victim");
        for (int t = 1; t <= 3; t++) begin
            do_access(1'b0, LW, make_addr(21'(t), 9'd200, 2'd0), 32'h0, 0, lat);
        end
        end_test("dirty_eviction", e0);
    endtask

    task automatic replacement_order();
        int e0;
        int lat;
        e0 = errors;
        do_access(1'b0, LW, make_addr(21'd1, 9'd300, 2'd0), 32'h0, 0, lat);     // A
        do_access(1'b0, LW, make_addr(21'd2, 9'd300, 2'd0), 32'h0, 0, lat);     // B
        do_access(1'b0, LW, make_addr(21'd1, 9'd300, 2'd0), 32'h0, 0, lat);
        do_access(1'b0, LW, make_addr(21'd3, 9'd300, 2'd0), 32'h0, 0, lat);     // C evicts B
        do_access(1'b0, LW, make_addr(21'd1, 9'd300, 2'd0), 32'h0, 0, lat);
        check_value(32'(lat), 32'(HIT_CYCLES), "re-read of A");
        do_access(1'b0, LW, make_addr(21'd2, 9'd300, 2'd0), 32'h0, 0, lat);
        check_value(32'(lat), 32'(MISS_CLEAN), "re-read of B");
        end_test("replacement", e0);
    endtask

    task automatic random_mix();
        int          e0;
        int          lat;
        int          hold;
        logic        write;
        logic [2:0]  f3;
        logic [2:0]  tag;
        logic [1:0]  set_low;
        logic [1:0]  off;
        logic [31:0] wdata;
        e0 = errors;
        for (int n = 0; n < 300; n++) begin
            write   = 1'(take_bits(1));
            f3      = 3'(take_bits(3));
            tag     = 3'(take_bits(3));
            set_low = 2'(take_bits(2));
            off     = 2'(take_bits(2));
            hold    = int'(take_bits(2));
            wdata   = take_bits(32);
            if (f3[1:0] == 2'd3) f3[1:0] = 2'd2;
            if (write) begin
                f3[2] = 1'b0;
            end else if (f3 == 3'd6) begin
                f3 = LW;
            end
            do_access(write, f3, make_addr(21'(tag), 9'd400 + 9'(set_low), off), wdata,
                      hold, lat);
        end
        end_test("random_mix", e0);
    endtask

    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_funct3 = 3'd0;
        req_addr   = 32'd0;
        req_wdata  = 32'd0;
        rsp_ready  = 1'b1;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = 32'd0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        word_round_trip();
        subword_access();
        dirty_eviction();
        replacement_order();
        random_mix();
        report_and_finish();
    end

endmodule

/* files.f */
design/cache_pkg.sv
design/cache_ctrl.sv
design/mem_wait_timer.sv
design/cache_ways.sv
design/load_store_align.sv
design/backing_mem.sv
design/data_cache_top.sv
bench/cache_assertions.sv
bench/cache_tb.sv

/* Makefile */
# Verilator build, run and lint for the data cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q '^STATUS: PASS$$' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
